// File: src/battlePkg.sv
package battlePkg;

    ////////////////////////////////////////////////////////////
    // Arena geometry
    ////////////////////////////////////////////////////////////

    localparam logic [7:0] ArenaMax   = 8'd200;
    localparam logic [7:0] PlayerSize = 8'd16;
    localparam logic [7:0] BulletSize = 8'd8;
    localparam logic [7:0] PlayerStep = 8'd4;
    localparam logic [7:0] BulletStep = 8'd6;
    localparam logic [7:0] StartPos   = 8'd92;

    // Highest legal top-left corner for each box
    localparam logic [7:0] PlayerLimit = ArenaMax - PlayerSize;
    localparam logic [7:0] BulletLimit = ArenaMax - BulletSize;

    ////////////////////////////////////////////////////////////
    // Hit points
    ////////////////////////////////////////////////////////////

    localparam logic [7:0] StartHp      = 8'd100;
    localparam logic [7:0] BulletDamage = 8'd5;
    localparam logic [7:0] AttackDamage = 8'd10;
    localparam logic [7:0] HealAmount   = 8'd8;

    // ASCII key codes from the UART
    localparam logic [7:0] KeyUp     = 8'h77;  // w
    localparam logic [7:0] KeyDown   = 8'h73;  // s
    localparam logic [7:0] KeyLeft   = 8'h61;  // a
    localparam logic [7:0] KeyRight  = 8'h64;  // d
    localparam logic [7:0] KeyAttack = 8'h6a;  // j
    localparam logic [7:0] KeyHeal   = 8'h6b;  // k

    typedef enum logic [1:0] {DirUp, DirDown, DirLeft, DirRight} moveDir;

    typedef struct packed {
        logic   move;
        moveDir dir;
        logic   attack;
        logic   heal;
    } playerCmd;

    typedef struct packed {
        logic [7:0] x;
        logic [7:0] y;
    } boxPos;

    typedef struct packed {
        boxPos pos;
        logic  blue;
    } bulletState;

    typedef struct packed {
        logic playerHit;
        logic monsterHit;
        logic playerHeal;
    } hpDelta;

    typedef struct packed {
        logic [7:0] playerHp;
        logic [7:0] monsterHp;
        logic       playerDead;
        logic       monsterDead;
    } battleStatus;

endpackage

// File: src/keyDecoder.sv
module keyDecoder (
    input  logic                clk_20hz,
    input  logic                reset,
    input  logic [7:0]          key,
    input  logic                keyValid,
    input  logic                frozen,
    output battlePkg::playerCmd cmd
);
    import battlePkg::*;

    playerCmd decoded;

    // Unknown codes fall through to an idle command
    always_comb
    begin
        decoded = '0;
        case (key)
            KeyUp:
            begin
                decoded.move = 1'b1;
                decoded.dir  = DirUp;
            end
            KeyDown:
            begin
                decoded.move = 1'b1;
                decoded.dir  = DirDown;
            end
            KeyLeft:
            begin
                decoded.move = 1'b1;
                decoded.dir  = DirLeft;
            end
            KeyRight:
            begin
                decoded.move = 1'b1;
                decoded.dir  = DirRight;
            end
            KeyAttack: decoded.attack = 1'b1;
            KeyHeal:   decoded.heal   = 1'b1;
            default:   decoded = '0;
        endcase
    end

    // Command lives for one tick only
    always_ff @(posedge clk_20hz)
    begin
        if (reset)
            cmd <= '0;
        else if (keyValid && !frozen)
            cmd <= decoded;
        else
            cmd <= '0;
    end

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////

    oneActionAtATime: assert property (@(posedge clk_20hz) disable iff (reset)
        $onehot0({cmd.move, cmd.attack, cmd.heal}));

endmodule

// File: src/playerMover.sv
module playerMover (
    input  logic                clk_20hz,
    input  logic                reset,
    input  battlePkg::playerCmd cmd,
    output battlePkg::boxPos    player,
    output logic                moved
);
    import battlePkg::*;

    boxPos nextPos;

    // One step in the commanded direction, clamped at the walls
    always_comb
    begin
        nextPos = player;
        if (cmd.move)
        begin
            case (cmd.dir)
                DirUp:
                    nextPos.y = (player.y < PlayerStep) ? 8'd0 : player.y - PlayerStep;
                DirDown:
                    nextPos.y = (player.y > PlayerLimit - PlayerStep) ? PlayerLimit
                                                                       : player.y + PlayerStep;
                DirLeft:
                    nextPos.x = (player.x < PlayerStep) ? 8'd0 : player.x - PlayerStep;
                DirRight:
                    nextPos.x = (player.x > PlayerLimit - PlayerStep) ? PlayerLimit
                                                                       : player.x + PlayerStep;
                default:
                    nextPos = player;
            endcase
        end
    end

    always_ff @(posedge clk_20hz)
    begin
        if (reset)
        begin
            player <= '{x: StartPos, y: StartPos};
            moved  <= 1'b0;
        end
        else
        begin
            player <= nextPos;
            moved  <= (nextPos != player);  // a move into a wall does not count
        end
    end

    playerInArena: assert property (@(posedge clk_20hz) disable iff (reset)
        player.x <= PlayerLimit && player.y <= PlayerLimit);

endmodule

// File: src/bulletField.sv
module bulletField (
    input  logic                  clk_20hz,
    input  logic                  reset,
    input  logic                  run,
    input  logic [7:0]            bulletRow,
    output battlePkg::bulletState bullet
);
    import battlePkg::*;

    logic [8:0] stepX;
    logic       wrap;

    // Extra bit keeps the sum honest near the right edge
    assign stepX = {1'b0, bullet.pos.x} + {1'b0, BulletStep};
    assign wrap  = stepX > {1'b0, BulletLimit};

    always_ff @(posedge clk_20hz)
    begin
        if (reset)
            bullet <= '0;
        else if (run)
        begin
            bullet.pos.y <= bulletRow;
            if (wrap)
            begin
                // Back to the left edge for a pass in the other colour
                bullet.pos.x <= 8'd0;
                bullet.blue  <= ~bullet.blue;
            end
            else
            begin
                bullet.pos.x <= stepX[7:0];
            end
        end
    end

endmodule

// File: src/collisionCheck.sv
module collisionCheck (
    input  battlePkg::boxPos player,
    input  battlePkg::boxPos bullet,
    output logic             hit
);
    import battlePkg::*;

    logic overlapX;
    logic overlapY;

    // Far edges may pass 255, so compare on nine bits
    assign overlapX = ({1'b0, player.x} < {1'b0, bullet.x} + {1'b0, BulletSize}) &&
                      ({1'b0, bullet.x} < {1'b0, player.x} + {1'b0, PlayerSize});

    assign overlapY = ({1'b0, player.y} < {1'b0, bullet.y} + {1'b0, BulletSize}) &&
                      ({1'b0, bullet.y} < {1'b0, player.y} + {1'b0, PlayerSize});

    assign hit = overlapX && overlapY;

endmodule

// File: src/damageCalculator.sv
module damageCalculator (
    input  logic                clk_20hz,
    input  logic                reset,
    input  battlePkg::playerCmd cmd,
    input  logic                hit,
    input  logic                moved,
    input  logic                blue,
    output battlePkg::hpDelta   delta
);
    import battlePkg::*;

    logic hurts;

    // White always hurts, blue only catches a moving player
    assign hurts = hit && (!blue || moved);

    always_ff @(posedge clk_20hz)
    begin
        if (reset)
            delta <= '0;
        else
        begin
            delta.playerHit  <= hurts;
            delta.monsterHit <= cmd.attack;
            delta.playerHeal <= cmd.heal;
        end
    end

endmodule

// File: src/hpTracker.sv
module hpTracker (
    input  logic                   clk_20hz,
    input  logic                   reset,
    input  battlePkg::hpDelta      delta,
    output battlePkg::battleStatus status,
    output logic                   frozen
);
    import battlePkg::*;

    logic signed [9:0] playerSum;
    logic [7:0]        playerNext;
    logic [7:0]        monsterNext;

    ////////////////////////////////////////////////////////////
    // Next hit points
    ////////////////////////////////////////////////////////////

    // Hit and heal in the same tick net out before clamping
    always_comb
    begin
        playerSum = $signed({2'b00, status.playerHp});
        if (delta.playerHit)
            playerSum = playerSum - $signed({2'b00, BulletDamage});
        if (delta.playerHeal)
            playerSum = playerSum + $signed({2'b00, HealAmount});

        if (playerSum < 10'sd0)
            playerNext = 8'd0;
        else if (playerSum > $signed({2'b00, StartHp}))
            playerNext = StartHp;
        else
            playerNext = playerSum[7:0];

        monsterNext = status.monsterHp;
        if (delta.monsterHit)
            monsterNext = (status.monsterHp < AttackDamage) ? 8'd0
                                                            : status.monsterHp - AttackDamage;
    end

    assign frozen = status.playerDead | status.monsterDead;

    always_ff @(posedge clk_20hz)
    begin
        if (reset)
            status <= '{playerHp: StartHp, monsterHp: StartHp,
                        playerDead: 1'b0, monsterDead: 1'b0};
        else if (!frozen)
        begin
            status.playerHp    <= playerNext;
            status.monsterHp   <= monsterNext;
            status.playerDead  <= (playerNext == 8'd0);
            status.monsterDead <= (monsterNext == 8'd0);
        end
    end

    hpCeiling: assert property (@(posedge clk_20hz) disable iff (reset)
        status.playerHp <= StartHp);

endmodule

// File: src/battleCore.sv
module battleCore (
    input  logic                   clk_20hz,
    input  logic                   reset,
    input  logic [7:0]             key,
    input  logic                   keyValid,
    input  logic [7:0]             bulletRow,
    input  logic                   run,
    output battlePkg::boxPos       player,
    output battlePkg::bulletState  bullet,
    output battlePkg::battleStatus status
);
    import battlePkg::*;

    playerCmd cmd;
    hpDelta   delta;
    logic     moved;
    logic     hit;
    logic     frozen;

    ////////////////////////////////////////////////////////////
    // Decode
    ////////////////////////////////////////////////////////////

    keyDecoder keyDecoder_i (
        .clk_20hz (clk_20hz),
        .reset    (reset),
        .key      (key),
        .keyValid (keyValid),
        .frozen   (frozen),
        .cmd      (cmd)
    );

    ////////////////////////////////////////////////////////////
    // Execute
    ////////////////////////////////////////////////////////////

    playerMover playerMover_i (
        .clk_20hz (clk_20hz),
        .reset    (reset),
        .cmd      (cmd),
        .player   (player),
        .moved    (moved)
    );

    bulletField bulletField_i (
        .clk_20hz  (clk_20hz),
        .reset     (reset),
        .run       (run),
        .bulletRow (bulletRow),
        .bullet    (bullet)
    );

    collisionCheck collisionCheck_i (
        .player (player),
        .bullet (bullet.pos),
        .hit    (hit)
    );

    damageCalculator damageCalculator_i (
        .clk_20hz (clk_20hz),
        .reset    (reset),
        .cmd      (cmd),
        .hit      (hit),
        .moved    (moved),
        .blue     (bullet.blue),
        .delta    (delta)
    );

    // Result stage, frozen loops back to stop the decoder
    hpTracker hpTracker_i (
        .clk_20hz (clk_20hz),
        .reset    (reset),
        .delta    (delta),
        .status   (status),
        .frozen   (frozen)
    );

endmodule

// File: sim/battleChecker.sv
module battleChecker (
    input  logic                   clk_20hz,
    input  logic                   reset,
    input  logic [7:0]             key,
    input  logic                   keyValid,
    input  logic [7:0]             bulletRow,
    input  logic                   run,
    input  battlePkg::boxPos       player,
    input  battlePkg::bulletState  bullet,
    input  battlePkg::battleStatus status,
    output int                     errors
);
    import battlePkg::*;

    // Whole core state, one entry per register stage
    typedef struct packed {
        playerCmd    cmd;
        boxPos       player;
        logic        moved;
        bulletState  bullet;
        hpDelta      delta;
        battleStatus status;
    } modelState;

    localparam int PlayerMaxPos = int'(ArenaMax) - int'(PlayerSize);
    localparam int BulletMaxPos = int'(ArenaMax) - int'(BulletSize);

    modelState model;
    logic      modelValid = 1'b0;
    int        errorCount = 0;

    assign errors = errorCount;

    function automatic int clampInt(input int v, input int lo, input int hi);
        return (v < lo) ? lo : ((v > hi) ? hi : v);
    endfunction

    function automatic playerCmd decodeKey(input logic [7:0] code);
        playerCmd c;
        c = '0;
        c.move = (code == KeyUp) || (code == KeyDown) || (code == KeyLeft) || (code == KeyRight);
        if (code == KeyDown)
            c.dir = DirDown;
        else if (code == KeyLeft)
            c.dir = DirLeft;
        else if (code == KeyRight)
            c.dir = DirRight;
        else
            c.dir = DirUp;
        c.attack = (code == KeyAttack);
        c.heal   = (code == KeyHeal);
        return c;
    endfunction

    function automatic logic overlaps(input boxPos p, input boxPos b);
        int px;
        int py;
        int bx;
        int by;
        px = int'(p.x);
        py = int'(p.y);
        bx = int'(b.x);
        by = int'(b.y);
        return (px < bx + int'(BulletSize)) && (bx < px + int'(PlayerSize)) &&
               (py < by + int'(BulletSize)) && (by < py + int'(PlayerSize));
    endfunction

    function automatic modelState resetModel();
        modelState r;
        r = '0;
        r.player.x         = StartPos;
        r.player.y         = StartPos;
        r.status.playerHp  = StartHp;
        r.status.monsterHp = StartHp;
        return r;
    endfunction

    ////////////////////////////////////////////////////////////
    // Reference model, one rising edge per call
    ////////////////////////////////////////////////////////////

    function automatic modelState stepModel(input modelState s, input logic [7:0] keyIn,
                                            input logic validIn, input logic [7:0] rowIn,
                                            input logic runIn);
        modelState n;
        logic      frozenNow;
        int        px;
        int        py;
        int        bx;
        int        hp;
        int        mhp;
        n = s;
        frozenNow = s.status.playerDead || s.status.monsterDead;
        n.cmd = (validIn && !frozenNow) ? decodeKey(keyIn) : '0;

        px = int'(s.player.x);
        py = int'(s.player.y);
        if (s.cmd.move)
        begin
            case (s.cmd.dir)
                DirUp:   py = py - int'(PlayerStep);
                DirDown: py = py + int'(PlayerStep);
                DirLeft: px = px - int'(PlayerStep);
                default: px = px + int'(PlayerStep);
            endcase
        end
        n.player.x = 8'(clampInt(px, 0, PlayerMaxPos));
        n.player.y = 8'(clampInt(py, 0, PlayerMaxPos));
        n.moved    = (n.player != s.player);

        if (runIn)
        begin
            bx = int'(s.bullet.pos.x) + int'(BulletStep);
            n.bullet.pos.y = rowIn;
            if (bx > BulletMaxPos)
            begin
                n.bullet.pos.x = 8'd0;
                n.bullet.blue  = !s.bullet.blue;
            end
            else
                n.bullet.pos.x = 8'(bx);
        end

        // Harm judged on the boxes as they stand before this edge
        n.delta.playerHit  = overlaps(s.player, s.bullet.pos) && (!s.bullet.blue || s.moved);
        n.delta.monsterHit = s.cmd.attack;
        n.delta.playerHeal = s.cmd.heal;

        if (!frozenNow)
        begin
            hp = int'(s.status.playerHp);
            if (s.delta.playerHit)
                hp = hp - int'(BulletDamage);
            if (s.delta.playerHeal)
                hp = hp + int'(HealAmount);
            hp  = clampInt(hp, 0, int'(StartHp));
            mhp = int'(s.status.monsterHp);
            if (s.delta.monsterHit)
                mhp = mhp - int'(AttackDamage);
            mhp = clampInt(mhp, 0, int'(StartHp));
            n.status.playerHp    = 8'(hp);
            n.status.monsterHp   = 8'(mhp);
            n.status.playerDead  = (hp == 0);
            n.status.monsterDead = (mhp == 0);
        end
        return n;
    endfunction

    task automatic checkValue(input string name, input logic [17:0] expected,
                              input logic [17:0] actual);
        if (actual !== expected)
        begin
            errorCount++;
            $display("Error at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
        end
    endtask

    always @(posedge clk_20hz)
    begin
        if (reset)
        begin
            model      <= resetModel();
            modelValid <= 1'b1;
        end
        else if (modelValid)
            model <= stepModel(model, key, keyValid, bulletRow, run);
    end

    // Registered outputs are settled by the falling edge
    always @(negedge clk_20hz)
    begin
        if (modelValid)
        begin
            checkValue("player", {2'b00, model.player}, {2'b00, player});
            checkValue("bullet", {1'b0, model.bullet}, {1'b0, bullet});
            checkValue("status", model.status, status);
        end
    end

endmodule

// File: sim/battleCoreTb.sv
module battleCoreTb;
    import battlePkg::*;

    localparam int StimCycles    = 1500;
    localparam int WallCycles    = 200;
    localparam int IdleCycles    = 30;
    localparam int BurstCycles   = 100;
    localparam int TailCycles    = 8;
    localparam int RandomCycles  = StimCycles - WallCycles - IdleCycles - BurstCycles
                                   - TailCycles;
    localparam int TimeoutCycles = 2 * StimCycles;

    logic        clk_20hz = 1'b0;
    logic        reset;
    logic [7:0]  key;
    logic        keyValid;
    logic [7:0]  bulletRow;
    logic        run;
    boxPos       player;
    bulletState  bullet;
    battleStatus status;

    logic [31:0] rngState = 32'd89;
    int          cycleCount = 0;
    int          valueErrors;
    int          otherFailures = 0;

    always #2 clk_20hz = ~clk_20hz;

    battleCore battleCore_i (
        .clk_20hz  (clk_20hz),
        .reset     (reset),
        .key       (key),
        .keyValid  (keyValid),
        .bulletRow (bulletRow),
        .run       (run),
        .player    (player),
        .bullet    (bullet),
        .status    (status)
    );

    battleChecker checker_i (
        .clk_20hz  (clk_20hz),
        .reset     (reset),
        .key       (key),
        .keyValid  (keyValid),
        .bulletRow (bulletRow),
        .run       (run),
        .player    (player),
        .bullet    (bullet),
        .status    (status),
        .errors    (valueErrors)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] v;
        v = s;
        v = v ^ (v << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    // Attacks stay rare here so the monster survives the random phase
    function automatic logic [7:0] pickKey(input logic [31:0] r);
        case (r[5:2])
            4'd0, 4'd1:        return KeyUp;
            4'd2, 4'd3:        return KeyDown;
            4'd4, 4'd5:        return KeyLeft;
            4'd6, 4'd7:        return KeyRight;
            4'd8, 4'd9, 4'd10: return KeyHeal;
            4'd11:             return (r[20:18] == 3'd0) ? KeyAttack : r[15:8];
            default:           return r[15:8];
        endcase
    endfunction

    // Half the rows land near the player to force overlaps
    function automatic logic [7:0] pickRow(input logic [31:0] r, input logic [7:0] playerY);
        int row;
        if (r[30])
            row = int'(playerY) + int'(r[19:16]) - 8;
        else
            row = int'(r[23:16]);
        if (row < 0)
            row = 0;
        if (row > int'(ArenaMax) - int'(BulletSize))
            row = int'(ArenaMax) - int'(BulletSize);
        return 8'(row);
    endfunction

    task automatic driveTick(input logic valid, input logic [7:0] code, input logic runLevel);
        @(negedge clk_20hz);
        keyValid = valid;
        key      = code;
        run      = runLevel;
    endtask

    ////////////////////////////////////////////////////////////
    // Watchdog
    ////////////////////////////////////////////////////////////

    always @(posedge clk_20hz)
    begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TimeoutCycles)
        begin
            $display("Timeout: the run did not finish within %0d cycles", TimeoutCycles);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    initial
    begin
        reset     = 1'b1;
        key       = 8'h00;
        keyValid  = 1'b0;
        bulletRow = 8'd96;
        run       = 1'b0;
        repeat (5) @(negedge clk_20hz);
        reset = 1'b0;

        // Random play
        for (int i = 0; i < RandomCycles; i++)
        begin
            rngState = xorshift(rngState);
            if (i % 40 == 0)
                bulletRow = pickRow(rngState, player.y);
            driveTick(rngState[0], pickKey(rngState), rngState[27:24] != 4'd0);
        end

        // Push into every wall
        bulletRow = 8'd96;
        repeat (WallCycles / 4) driveTick(1'b1, KeyUp, 1'b1);
        repeat (WallCycles / 4) driveTick(1'b1, KeyLeft, 1'b1);
        repeat (WallCycles / 4) driveTick(1'b1, KeyRight, 1'b1);
        repeat (WallCycles / 4) driveTick(1'b1, KeyDown, 1'b1);

        // Bullet parked
        repeat (IdleCycles) driveTick(1'b0, 8'h00, 1'b0);

        // Attack burst with heals mixed in to probe the freeze
        for (int i = 0; i < BurstCycles; i++)
            driveTick(1'b1, (i % 4 == 3) ? KeyHeal : KeyAttack, 1'b1);

        // Move keys after game over must leave the player in place
        repeat (TailCycles / 2) driveTick(1'b1, KeyUp, 1'b1);
        repeat (TailCycles / 2) driveTick(1'b0, 8'h00, 1'b1);
        #1;

        if (!(status.playerDead || status.monsterDead))
        begin
            $display("Failure: neither side died by the end of the attack burst");
            otherFailures++;
        end
        $display("Closing counts: %0d value errors, %0d other failures",
                 valueErrors, otherFailures);
        if (valueErrors == 0 && otherFailures == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

// File: sim.f
src/battlePkg.sv
src/keyDecoder.sv
src/playerMover.sv
src/bulletField.sv
src/collisionCheck.sv
src/damageCalculator.sv
src/hpTracker.sv
src/battleCore.sv
sim/battleChecker.sv
sim/battleCoreTb.sv

// File: run.sh
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert -Wno-fatal --top-module battleCoreTb \
    -f sim.f -o battleCoreSim > build.log 2>&1 \
    && ./obj_dir/battleCoreSim > sim.log 2>&1

grep -qx "RESULT: PASS" sim.log && echo "Simulation passed" \
    || { echo "Simulation failed, see build.log and sim.log"; exit 1; }
